/* hw/audio_pkg.sv */
`default_nettype none

package audio_pkg;

	// datapath widths
	localparam int BYTE_W   = 8;
	localparam int SAMPLE_W = 16;
	localparam int DIV_W    = 16;

	// fifo sizing, fill needs one bit more than the pointers
	localparam int FIFO_DEPTH     = 64;
	localparam int FIFO_HIGH_MARK = 56;
	localparam int PTR_W          = $clog2(FIFO_DEPTH);
	localparam int FILL_W         = PTR_W + 1;

	// clocks per uart bit, small for simulation
	localparam int UART_DIV = 8;

	// sample-rate divider
	localparam int DIV_RESET = 32;
	localparam int DIV_MIN   = 2;

	localparam int AXIL_ADDR_W = 32;
	localparam int AXIL_DATA_W = 32;

	typedef logic [BYTE_W-1:0]            byte_t;
	typedef logic [SAMPLE_W-1:0]          sample_t;
	typedef logic [FILL_W-1:0]            fill_t;
	typedef logic [DIV_W-1:0]             div_t;
	typedef logic [PTR_W-1:0]             fifo_ptr_t;
	typedef logic [$clog2(UART_DIV)-1:0]  baud_cnt_t;
	typedef logic [$clog2(BYTE_W)-1:0]    bit_idx_t;
	typedef logic [AXIL_ADDR_W-1:0]       axil_addr_t;
	typedef logic [AXIL_DATA_W-1:0]       axil_data_t;
	typedef logic [AXIL_DATA_W/8-1:0]     axil_strb_t;
	typedef logic [1:0]                   axil_resp_t;

	// register map
	localparam axil_addr_t REG_CTRL_ADDR   = 'h0;
	localparam axil_addr_t REG_DIV_ADDR    = 'h4;
	localparam axil_addr_t REG_STATUS_ADDR = 'h8;
	localparam int         STATUS_OVF_BIT  = 8;
	localparam int         STATUS_UDF_BIT  = 9;
	localparam axil_resp_t AXI_RESP_OKAY   = 2'b00;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} uart_state_e;

	typedef struct packed {
		logic       awvalid;
		axil_addr_t awaddr;
		logic       wvalid;
		axil_data_t wdata;
		axil_strb_t wstrb;
		logic       bready;
		logic       arvalid;
		axil_addr_t araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       arready;
		logic       bvalid;
		axil_resp_t bresp;
		logic       rvalid;
		axil_data_t rdata;
		axil_resp_t rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic enable;
		div_t div;
	} csr_ctrl_t;

	typedef struct packed {
		fill_t fill;
		logic  overflow;
		logic  underflow;
	} fifo_status_t;

endpackage

`default_nettype wire

/* hw/uart_rx.sv */
`default_nettype none

module uart_rx (
	input  wire                 CLK_IN,
	input  wire                 reset_i,
	input  wire                 rx_i,
	output audio_pkg::byte_t    byte_o,
	output logic                byte_valid_o
);
	import audio_pkg::*;

	logic        rx_meta;
	logic        rx_sync;
	uart_state_e state;
	baud_cnt_t   baud_cnt;
	bit_idx_t    bit_idx;
	byte_t       shift_q;
	logic        baud_half;
	logic        baud_full;

	assign baud_half = (baud_cnt == baud_cnt_t'(UART_DIV / 2 - 1));
	assign baud_full = (baud_cnt == baud_cnt_t'(UART_DIV - 1));
	assign byte_o    = shift_q;

	// two-flop synchronizer, idle line is high
	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			state        <= IDLE;
			baud_cnt     <= '0;
			bit_idx      <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			baud_cnt     <= baud_cnt + baud_cnt_t'(1);
			case (state)
				IDLE: begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= START;
				end
				// recheck at mid-bit to reject glitches
				START: begin
					if (baud_half) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_sync ? IDLE : DATA;
					end
				end
				DATA: begin
					if (baud_full) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + bit_idx_t'(1);
						if (bit_idx == bit_idx_t'(BYTE_W - 1))
							state <= STOP;
					end
				end
				STOP: begin
					if (baud_full) begin
						// framing error drops the byte
						byte_valid_o <= rx_sync;
						state        <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge CLK_IN) begin
		if (state == DATA && baud_full)
			shift_q <= {rx_sync, shift_q[BYTE_W-1:1]};
	end

	a_single_strobe: assert property (@(posedge CLK_IN) disable iff (reset_i)
		byte_valid_o |=> !byte_valid_o)
		else $error("byte_valid_o high for two cycles");

endmodule

`default_nettype wire

/* hw/sample_assembler.sv */
`default_nettype none

module sample_assembler (
	input  wire                 CLK_IN,
	input  wire                 reset_i,
	input  wire audio_pkg::byte_t byte_i,
	input  wire                 byte_valid_i,
	output audio_pkg::sample_t  sample_o,
	output logic                push_o
);
	import audio_pkg::*;

	byte_t low_q;
	logic  have_low;

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			have_low <= 1'b0;
			push_o   <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (byte_valid_i) begin
				have_low <= !have_low;
				push_o   <= have_low;
			end
		end
	end

	// first byte of a pair is the low half
	always_ff @(posedge CLK_IN) begin
		if (byte_valid_i) begin
			if (!have_low)
				low_q <= byte_i;
			else
				sample_o <= {byte_i, low_q};
		end
	end

endmodule

`default_nettype wire

/* hw/sample_fifo.sv */
`default_nettype none

module sample_fifo (
	input  wire                     CLK_IN,
	input  wire                     reset_i,
	input  wire                     push_i,
	input  wire audio_pkg::sample_t sample_i,
	input  wire                     pop_i,
	output audio_pkg::sample_t      head_o,
	output logic                    empty_o,
	output audio_pkg::fifo_status_t status_o,
	output logic                    cts_o
);
	import audio_pkg::*;

	sample_t   mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	fill_t     fill_q;
	logic      full;
	logic      do_push;
	logic      do_pop;
	logic      ovf_q;

	assign full    = (fill_q == fill_t'(FIFO_DEPTH));
	assign empty_o = (fill_q == '0);
	// a push into a full fifo is dropped
	assign do_push = push_i && !full;
	assign do_pop  = pop_i && !empty_o;

	// show-ahead read
	assign head_o = mem[rd_ptr];

	// flow control watermark
	assign cts_o = (fill_q < fill_t'(FIFO_HIGH_MARK));

	assign status_o.fill      = fill_q;
	assign status_o.overflow  = ovf_q;
	// the dac sees the sample tick and flags underflow itself
	assign status_o.underflow = 1'b0;

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_q <= '0;
			ovf_q  <= 1'b0;
		end else begin
			ovf_q <= push_i && full;
			if (do_push)
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			case ({do_push, do_pop})
				2'b10:   fill_q <= fill_q + fill_t'(1);
				2'b01:   fill_q <= fill_q - fill_t'(1);
				default: fill_q <= fill_q;
			endcase
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (do_push)
			mem[wr_ptr] <= sample_i;
	end

	a_no_pop_empty: assert property (@(posedge CLK_IN) disable iff (reset_i)
		!(pop_i && empty_o))
		else $error("pop while fifo empty");

	a_fill_bound: assert property (@(posedge CLK_IN) disable iff (reset_i)
		fill_q <= fill_t'(FIFO_DEPTH))
		else $error("fifo fill above depth");

endmodule

`default_nettype wire

/* hw/sigma_delta_dac.sv */
`default_nettype none

module sigma_delta_dac (
	input  wire                     CLK_IN,
	input  wire                     reset_i,
	input  wire audio_pkg::csr_ctrl_t ctrl_i,
	input  wire audio_pkg::sample_t head_i,
	input  wire                     empty_i,
	output logic                    pop_o,
	output logic                    underflow_o,
	output logic                    audio_o
);
	import audio_pkg::*;

	div_t                div_eff;
	div_t                tick_cnt;
	logic                tick;
	sample_t             held_q;
	sample_t             acc_q;
	logic [SAMPLE_W:0]   sum;

	// divider below the minimum is clamped
	assign div_eff = (ctrl_i.div < div_t'(DIV_MIN)) ? div_t'(DIV_MIN) : ctrl_i.div;
	assign tick    = ctrl_i.enable && (tick_cnt >= div_eff - div_t'(1));

	assign pop_o       = tick && !empty_i;
	assign underflow_o = tick && empty_i;

	// carry out of the accumulator is the one-bit output
	assign sum = {1'b0, acc_q} + {1'b0, held_q};

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			tick_cnt <= '0;
		end else if (!ctrl_i.enable || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + div_t'(1);
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			held_q  <= '0;
			acc_q   <= '0;
			audio_o <= 1'b0;
		end else if (underflow_o) begin
			// starved, go silent
			held_q  <= '0;
			acc_q   <= '0;
			audio_o <= 1'b0;
		end else begin
			acc_q   <= sum[SAMPLE_W-1:0];
			audio_o <= sum[SAMPLE_W];
			if (pop_o)
				held_q <= head_i;
		end
	end

endmodule

`default_nettype wire

/* hw/audio_csr.sv */
`default_nettype none

module audio_csr (
	input  wire                       CLK_IN,
	input  wire                       reset_i,
	input  wire audio_pkg::axil_req_t axil_req_i,
	output audio_pkg::axil_rsp_t      axil_rsp_o,
	input  wire audio_pkg::fifo_status_t status_i,
	input  wire                       underflow_i,
	output audio_pkg::csr_ctrl_t      ctrl_o
);
	import audio_pkg::*;

	logic       awready_q;
	logic       arready_q;
	logic       bvalid_q;
	logic       rvalid_q;
	axil_data_t rdata_q;
	axil_data_t rd_mux;
	logic       wr_fire;
	logic       rd_fire;
	logic       enable_q;
	div_t       div_q;
	logic       ovf_q;
	logic       udf_q;
	logic       clr_ovf;
	logic       clr_udf;
	logic       status_wr;

	assign wr_fire = awready_q && axil_req_i.awvalid && axil_req_i.wvalid;
	assign rd_fire = arready_q && axil_req_i.arvalid;

	assign status_wr = wr_fire && (axil_req_i.awaddr == REG_STATUS_ADDR) &&
		axil_req_i.wstrb[1];
	assign clr_ovf = status_wr && axil_req_i.wdata[STATUS_OVF_BIT];
	assign clr_udf = status_wr && axil_req_i.wdata[STATUS_UDF_BIT];

	always_comb begin
		axil_rsp_o.awready = awready_q;
		axil_rsp_o.wready  = awready_q;
		axil_rsp_o.arready = arready_q;
		axil_rsp_o.bvalid  = bvalid_q;
		axil_rsp_o.bresp   = AXI_RESP_OKAY;
		axil_rsp_o.rvalid  = rvalid_q;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = AXI_RESP_OKAY;
		ctrl_o.enable      = enable_q;
		ctrl_o.div         = div_q;
	end

	// unmapped addresses read as zero
	always_comb begin
		rd_mux = '0;
		case (axil_req_i.araddr)
			REG_CTRL_ADDR: rd_mux[0] = enable_q;
			REG_DIV_ADDR: rd_mux[DIV_W-1:0] = div_q;
			REG_STATUS_ADDR: begin
				rd_mux[FILL_W-1:0]    = status_i.fill;
				rd_mux[STATUS_OVF_BIT] = ovf_q;
				rd_mux[STATUS_UDF_BIT] = udf_q;
			end
			default: rd_mux = '0;
		endcase
	end

	// one outstanding write and one outstanding read
	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			awready_q <= 1'b0;
			arready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			awready_q <= !awready_q && !bvalid_q &&
				axil_req_i.awvalid && axil_req_i.wvalid;
			arready_q <= !arready_q && !rvalid_q && axil_req_i.arvalid;
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (axil_req_i.bready)
				bvalid_q <= 1'b0;
			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (axil_req_i.rready)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (rd_fire)
			rdata_q <= rd_mux;
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			enable_q <= 1'b0;
			div_q    <= div_t'(DIV_RESET);
			ovf_q    <= 1'b0;
			udf_q    <= 1'b0;
		end else begin
			if (wr_fire) begin
				case (axil_req_i.awaddr)
					REG_CTRL_ADDR: begin
						if (axil_req_i.wstrb[0])
							enable_q <= axil_req_i.wdata[0];
					end
					REG_DIV_ADDR: begin
						if (axil_req_i.wstrb[0])
							div_q[7:0] <= axil_req_i.wdata[7:0];
						if (axil_req_i.wstrb[1])
							div_q[15:8] <= axil_req_i.wdata[15:8];
					end
					default: ;
				endcase
			end
			// new events win over a clear in the same cycle
			ovf_q <= (ovf_q && !clr_ovf) || status_i.overflow;
			udf_q <= (udf_q && !clr_udf) || underflow_i;
		end
	end

	a_bvalid_hold: assert property (@(posedge CLK_IN) disable iff (reset_i)
		axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
		else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

/* hw/audio_stream_top.sv */
`default_nettype none

module audio_stream_top (
	input  wire                       CLK_IN,
	input  wire                       reset_i,
	input  wire                       uart_rx_i,
	output logic                      uart_cts_o,
	output logic                      audio_o,
	input  wire audio_pkg::axil_req_t axil_req_i,
	output audio_pkg::axil_rsp_t      axil_rsp_o
);
	import audio_pkg::*;

	byte_t        rx_byte;
	logic         rx_byte_valid;
	sample_t      asm_sample;
	logic         asm_push;
	sample_t      fifo_head;
	logic         fifo_empty;
	fifo_status_t fifo_status;
	logic         dac_pop;
	logic         dac_underflow;
	csr_ctrl_t    csr_ctrl;

	uart_rx u_uart_rx (
		.CLK_IN       (CLK_IN),
		.reset_i      (reset_i),
		.rx_i         (uart_rx_i),
		.byte_o       (rx_byte),
		.byte_valid_o (rx_byte_valid)
	);

	sample_assembler u_sample_assembler (
		.CLK_IN       (CLK_IN),
		.reset_i      (reset_i),
		.byte_i       (rx_byte),
		.byte_valid_i (rx_byte_valid),
		.sample_o     (asm_sample),
		.push_o       (asm_push)
	);

	sample_fifo u_sample_fifo (
		.CLK_IN   (CLK_IN),
		.reset_i  (reset_i),
		.push_i   (asm_push),
		.sample_i (asm_sample),
		.pop_i    (dac_pop),
		.head_o   (fifo_head),
		.empty_o  (fifo_empty),
		.status_o (fifo_status),
		.cts_o    (uart_cts_o)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.CLK_IN      (CLK_IN),
		.reset_i     (reset_i),
		.ctrl_i      (csr_ctrl),
		.head_i      (fifo_head),
		.empty_i     (fifo_empty),
		.pop_o       (dac_pop),
		.underflow_o (dac_underflow),
		.audio_o     (audio_o)
	);

	// register block beside the streaming path
	audio_csr u_audio_csr (
		.CLK_IN      (CLK_IN),
		.reset_i     (reset_i),
		.axil_req_i  (axil_req_i),
		.axil_rsp_o  (axil_rsp_o),
		.status_i    (fifo_status),
		.underflow_i (dac_underflow),
		.ctrl_o      (csr_ctrl)
	);

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// reset released on a rising edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* dv/audio_stream_tb.sv */
`default_nettype none

module audio_stream_tb;
	import audio_pkg::*;

	// longest run is about 13k cycles of mostly uart frames
	localparam int MAX_CYCLES    = 40000;
	localparam int SETTLE_CYCLES = 2 * UART_DIV;
	localparam axil_data_t OVF_FLAG = axil_data_t'(1) << STATUS_OVF_BIT;
	localparam axil_data_t UDF_FLAG = axil_data_t'(1) << STATUS_UDF_BIT;

	logic        CLK_IN;
	logic        reset;
	logic        rx_line;
	logic        cts;
	logic        audio;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;

	logic [31:0] rng_state;
	int          cycle_count = 0;
	sample_t     exp_q[$];

	// reference model state
	logic        model_enable;
	div_t        model_div;
	div_t        model_cnt;
	sample_t     model_held;
	sample_t     model_acc;
	logic        model_audio;
	int          model_underflows;

	tb_clock u_tb_clock (
		.clk_o   (CLK_IN),
		.reset_o (reset)
	);

	audio_stream_top u_audio_stream_top (
		.CLK_IN     (CLK_IN),
		.reset_i    (reset),
		.uart_rx_i  (rx_line),
		.uart_cts_o (cts),
		.audio_o    (audio),
		.axil_req_i (axil_req),
		.axil_rsp_o (axil_rsp)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_run($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
			$time, name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
		@(posedge CLK_IN);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= '1;
		// offered twice so the repeat waits while bvalid is pending
		for (int n = 0; n < 2; n++) begin
			@(negedge CLK_IN);
			while (!axil_rsp.awready)
				@(negedge CLK_IN);
			// register takes the write on this edge
			@(posedge CLK_IN);
			if (n == 1) begin
				axil_req.awvalid <= 1'b0;
				axil_req.wvalid  <= 1'b0;
			end
			if (addr == REG_CTRL_ADDR)
				model_enable <= data[0];
			else if (addr == REG_DIV_ADDR)
				model_div <= data[DIV_W-1:0];
			// bready late by one cycle so bvalid has to wait
			@(posedge CLK_IN);
			axil_req.bready <= 1'b1;
			@(posedge CLK_IN);
			axil_req.bready <= 1'b0;
		end
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t first,
		output axil_data_t second);
		@(posedge CLK_IN);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		// offered twice so the repeat waits while rvalid is pending
		for (int n = 0; n < 2; n++) begin
			@(negedge CLK_IN);
			while (!axil_rsp.arready)
				@(negedge CLK_IN);
			@(posedge CLK_IN);
			if (n == 1)
				axil_req.arvalid <= 1'b0;
			@(posedge CLK_IN);
			axil_req.rready <= 1'b1;
			@(negedge CLK_IN);
			if (n == 0)
				first = axil_rsp.rdata;
			else
				second = axil_rsp.rdata;
			@(posedge CLK_IN);
			axil_req.rready <= 1'b0;
		end
	endtask

	task automatic check_reg(input string name, input axil_addr_t addr,
		input axil_data_t exp);
		axil_data_t first;
		axil_data_t second;
		read_reg(addr, first, second);
		if (first !== exp)
			report_mismatch(name, first, exp);
		if (second !== exp)
			report_mismatch(name, second, exp);
	endtask

	task automatic check_cts(input logic exp);
		@(negedge CLK_IN);
		if (cts !== exp)
			report_mismatch("uart_cts_o", 32'(cts), 32'(exp));
	endtask

	// 8N1 frame sent lsb first
	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge CLK_IN);
		for (int i = 0; i < 10; i++) begin
			rx_line <= frame[i];
			repeat (UART_DIV) @(posedge CLK_IN);
		end
	endtask

	task automatic send_sample(input sample_t s);
		send_byte(s[7:0]);
		send_byte(s[15:8]);
		// samples beyond capacity are dropped by the fifo
		if (exp_q.size() < FIFO_DEPTH)
			exp_q.push_back(s);
	endtask

	task automatic send_random(input int count);
		for (int i = 0; i < count; i++) begin
			rng_state = xorshift32(rng_state);
			send_sample(rng_state[15:0]);
		end
	endtask

	// last frame lands in the fifo within a bit time of its stop bit
	task automatic settle_uart();
		repeat (SETTLE_CYCLES) @(posedge CLK_IN);
	endtask

	// tick every div cycles from enable and the carry of acc + held drives audio
	always @(posedge CLK_IN) begin
		div_t              eff;
		logic              tick;
		logic [SAMPLE_W:0] sum;
		eff  = (model_div < div_t'(DIV_MIN)) ? div_t'(DIV_MIN) : model_div;
		tick = model_enable && (model_cnt + div_t'(1) == eff);
		sum  = {1'b0, model_acc} + {1'b0, model_held};
		if (reset) begin
			model_cnt        <= '0;
			model_held       <= '0;
			model_acc        <= '0;
			model_audio      <= 1'b0;
			model_underflows <= 0;
		end else begin
			if (!model_enable || tick)
				model_cnt <= '0;
			else
				model_cnt <= model_cnt + div_t'(1);
			if (tick && exp_q.size() == 0) begin
				model_held       <= '0;
				model_acc        <= '0;
				model_audio      <= 1'b0;
				model_underflows <= model_underflows + 1;
			end else begin
				model_acc   <= sum[SAMPLE_W-1:0];
				model_audio <= sum[SAMPLE_W];
				if (tick)
					model_held <= exp_q.pop_front();
			end
		end
	end

	always @(posedge CLK_IN) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			fail_run("timeout: the test sequence did not finish in time");
	end

	a_audio_model: assert property (@(posedge CLK_IN) disable iff (reset)
		audio == model_audio)
		else report_mismatch("audio_o", 32'($sampled(audio)), 32'($sampled(model_audio)));

	a_aw_w_together: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.awready == axil_rsp.wready)
		else fail_run("awready and wready were not raised together");

	a_bvalid_follows: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.awready && axil_req.awvalid && axil_req.wvalid |=> axil_rsp.bvalid)
		else fail_run("bvalid did not follow the write handshake");

	a_rvalid_follows: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.arready && axil_req.arvalid |=> axil_rsp.rvalid)
		else fail_run("rvalid did not follow the read handshake");

	a_bvalid_hold: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
		else fail_run("bvalid dropped before bready");

	a_rvalid_hold: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
		else fail_run("rvalid dropped before rready");

	a_no_write_pending: assert property (@(posedge CLK_IN) disable iff (reset)
		!(axil_rsp.awready && axil_rsp.bvalid))
		else fail_run("a write was accepted while bvalid was pending");

	a_no_read_pending: assert property (@(posedge CLK_IN) disable iff (reset)
		!(axil_rsp.arready && axil_rsp.rvalid))
		else fail_run("a read was accepted while rvalid was pending");

	a_bresp_okay: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.bvalid |-> axil_rsp.bresp == AXI_RESP_OKAY)
		else report_mismatch("bresp", 32'($sampled(axil_rsp.bresp)),
			32'(AXI_RESP_OKAY));

	a_rresp_okay: assert property (@(posedge CLK_IN) disable iff (reset)
		axil_rsp.rvalid |-> axil_rsp.rresp == AXI_RESP_OKAY)
		else report_mismatch("rresp", 32'($sampled(axil_rsp.rresp)),
			32'(AXI_RESP_OKAY));

	initial begin
		axil_req     = '0;
		rx_line      = 1'b1;
		rng_state    = 32'd23;
		model_enable = 1'b0;
		model_div    = div_t'(DIV_RESET);
		@(negedge reset);

		// register access
		check_reg("rdata CTRL", REG_CTRL_ADDR, 32'd0);
		check_reg("rdata DIV", REG_DIV_ADDR, axil_data_t'(DIV_RESET));
		check_reg("rdata STATUS", REG_STATUS_ADDR, 32'd0);
		write_reg(REG_DIV_ADDR, 32'hABCD_1234);
		check_reg("rdata DIV", REG_DIV_ADDR, 32'h0000_1234);
		// long divider so no tick before enable goes back off
		write_reg(REG_CTRL_ADDR, 32'hFFFF_FFFF);
		check_reg("rdata CTRL", REG_CTRL_ADDR, 32'd1);
		write_reg(REG_CTRL_ADDR, 32'd0);
		check_reg("rdata CTRL", REG_CTRL_ADDR, 32'd0);
		check_reg("rdata unmapped", 32'h0000_000C, 32'd0);
		check_reg("rdata unmapped", 32'h0000_0100, 32'd0);

		// byte pairing with the player stopped
		send_sample(16'h0000);
		send_sample(16'hFFFF);
		send_random(8);
		settle_uart();
		check_reg("rdata STATUS", REG_STATUS_ADDR, 32'd10);

		// modulation until the queue drains
		write_reg(REG_DIV_ADDR, 32'd20);
		write_reg(REG_CTRL_ADDR, 32'd1);
		while (exp_q.size() != 0)
			@(posedge CLK_IN);

		// underflow keeps the output silent
		while (model_underflows < 2)
			@(posedge CLK_IN);
		check_reg("rdata STATUS", REG_STATUS_ADDR, UDF_FLAG);
		write_reg(REG_CTRL_ADDR, 32'd0);
		write_reg(REG_STATUS_ADDR, UDF_FLAG);
		check_reg("rdata STATUS", REG_STATUS_ADDR, 32'd0);

		// watermark and overflow
		send_random(FIFO_HIGH_MARK - 1);
		settle_uart();
		check_cts(1'b1);
		send_random(1);
		settle_uart();
		check_cts(1'b0);
		check_reg("rdata STATUS", REG_STATUS_ADDR, axil_data_t'(FIFO_HIGH_MARK));
		send_random(10);
		settle_uart();
		check_reg("rdata STATUS", REG_STATUS_ADDR, axil_data_t'(FIFO_DEPTH) | OVF_FLAG);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/audio_pkg.sv
hw/uart_rx.sv
hw/sample_assembler.sv
hw/sample_fifo.sv
hw/sigma_delta_dac.sv
hw/audio_csr.sv
hw/audio_stream_top.sv
dv/tb_clock.sv
dv/audio_stream_tb.sv

/* Makefile */
SRCS := $(shell cat build.f)

.PHONY: run clean

run: obj_dir/Vaudio_stream_tb
	./obj_dir/Vaudio_stream_tb

obj_dir/Vaudio_stream_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module audio_stream_tb -f build.f

clean:
	rm -rf obj_dir
